/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ****************************************
// memory sizes, counted in 32-bit words
// ****************************************

`define CPU_IMEM_DEPTH 64   // instruction words
`define CPU_DMEM_DEPTH 64   // data words

// ****************************************
// register file
// ****************************************

// $0 included, reads as zero
`define CPU_REG_COUNT 32

`endif

/* cpu_pkg.sv */
package cpu_pkg;

    // primary opcode field, instruction[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // R-type, see funct
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // R-type function field, instruction[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FW_NONE = 2'd0,  // value read in decode
        FW_MEM  = 2'd1,  // alu result in memory stage
        FW_WB   = 2'd2   // writeback data
    } forward_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    alu_src;    // operand b from immediate
        logic    reg_dst;    // dest is rd, else rt
        logic    branch;
        logic    branch_ne;  // bne, taken when not zero
        alu_op_t alu_op;
    } ctrl_word_t;

    // ****************************************
    // stage borders
    // ****************************************

    typedef struct packed {
        logic [31:0] pc_next;
        logic [31:0] instruction;
    } fd_stage_t;

    typedef struct packed {
        ctrl_word_t  ctrl;
        logic [31:0] operand_a;
        logic [31:0] operand_b;
        logic [31:0] imm;        // sign extended
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [31:0] pc_next;
    } de_stage_t;

    typedef struct packed {
        ctrl_word_t  ctrl;
        logic [31:0] alu_result;
        logic        zero;
        logic [31:0] store_data;
        logic [4:0]  dest;
        logic [31:0] branch_target;
    } em_stage_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_to_reg;
        logic [31:0] alu_result;
        logic [31:0] load_data;
        logic [4:0]  dest;
    } mw_stage_t;

    typedef struct packed {
        forward_t forward_a;
        forward_t forward_b;
        logic     stall;  // hold pc and F/D, bubble into D/E
        logic     flush;  // clear F/D, D/E and E/M
    } hazard_t;

    typedef struct packed {
        logic [31:0] addr;   // word address
        logic [31:0] wdata;
        logic        we;
    } dmem_req_t;

endpackage

/* cpu_control.sv */
module cpu_control import cpu_pkg::*; (
    input  logic [31:0] instruction,
    output ctrl_word_t  ctrl
);
    opcode_t opcode;
    funct_t  funct;

    assign opcode = opcode_t'(instruction[31:26]);
    assign funct  = funct_t'(instruction[5:0]);

    always_comb begin
        ctrl = '0; // no-op unless decoded below
        case (opcode)
            OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;  // result goes to rd
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                    default: ctrl = '0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_LUI;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;  // address = rs + imm
                ctrl.alu_op     = ALU_ADD;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (opcode == OP_BNE);
                ctrl.alu_op    = ALU_SUB; // compare rs and rt via zero flag
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* cpu_alu.sv */
module cpu_alu import cpu_pkg::*; (
    input  logic [31:0] src_a,
    input  logic [31:0] src_b,
    input  alu_op_t     op,
    input  logic [4:0]  shamt,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (op)
            ALU_ADD: result = src_a + src_b;
            ALU_SUB: result = src_a - src_b;
            ALU_AND: result = src_a & src_b;
            ALU_OR:  result = src_a | src_b;
            ALU_SLT: result = {31'b0, $signed(src_a) < $signed(src_b)};
            ALU_SLL: result = src_b << shamt;   // shifts take rt
            ALU_SRL: result = src_b >> shamt;
            ALU_LUI: result = {src_b[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    // branch compare, beq and bne both use ALU_SUB
    assign zero = (result == '0);

endmodule

/* cpu_register_file.sv */
`include "cpu_settings.svh"

module cpu_register_file (
    input  logic        clk,
    input  logic [4:0]  read_addr_a,
    input  logic [4:0]  read_addr_b,
    input  logic [4:0]  debug_addr,
    input  logic [4:0]  write_addr,
    input  logic [31:0] write_data,
    input  logic        write_enable,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] debug_data
);
    logic [31:0] regs [`CPU_REG_COUNT];

    // writeback data is visible to decode in the same cycle
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == '0)
            return '0;
        else if (write_enable && addr == write_addr)
            return write_data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (write_enable && write_addr != '0)
            regs[write_addr] <= write_data;
    end

    always_comb begin
        read_data_a = read_port(read_addr_a);
        read_data_b = read_port(read_addr_b);
        debug_data  = read_port(debug_addr);
    end

endmodule

/* cpu_hazard_unit.sv */
module cpu_hazard_unit import cpu_pkg::*; (
    input  logic [4:0] de_rs,
    input  logic [4:0] de_rt,
    input  logic [4:0] fd_rs,
    input  logic [4:0] fd_rt,
    input  em_stage_t  em,
    input  mw_stage_t  mw,
    input  logic [4:0] de_dest,
    input  logic       de_mem_to_reg,
    input  logic       branch_taken,
    output hazard_t    hazard
);
    logic load_use;

    // memory stage is younger, so it wins over writeback
    function automatic forward_t select_forward(input logic [4:0] src,
                                                input em_stage_t em_s,
                                                input mw_stage_t mw_s);
        if (src == '0)
            return FW_NONE;  // $0 is never forwarded
        else if (em_s.ctrl.reg_write && em_s.dest == src)
            return FW_MEM;
        else if (mw_s.reg_write && mw_s.dest == src)
            return FW_WB;
        else
            return FW_NONE;
    endfunction

    // load in execute, its user in decode
    assign load_use = de_mem_to_reg && de_dest != '0 &&
                      (fd_rs == de_dest || fd_rt == de_dest);

    always_comb begin
        hazard.forward_a = select_forward(de_rs, em, mw);
        hazard.forward_b = select_forward(de_rt, em, mw);
        hazard.flush     = branch_taken;
        hazard.stall     = load_use && !branch_taken; // flush wins
    end

endmodule

/* cpu_pipeline.sv */
module cpu_pipeline import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  reg_addr,    // debug register select
    output logic [31:0] reg_data,    // debug register value, pc at 0
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output dmem_req_t   dmem,
    input  logic [31:0] dmem_rdata
);
    logic [31:0] pc;
    fd_stage_t   fd, fd_next;
    de_stage_t   de, de_next;
    em_stage_t   em, em_next;
    mw_stage_t   mw, mw_next;
    hazard_t     hazard;
    logic        branch_taken;

    // ****************************************
    // F - fetch
    // ****************************************

    logic [31:0] pc_plus_one;
    logic [31:0] pc_new;

    assign pc_plus_one = pc + 32'd1;  // word addressed
    assign pc_new      = branch_taken ? em.branch_target : pc_plus_one;
    assign imem_addr   = pc;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= '0;
        else if (!hazard.stall)
            pc <= pc_new;
    end

    always_comb begin
        fd_next.pc_next     = pc_plus_one;
        fd_next.instruction = imem_data;
    end

    always_ff @(posedge clk) begin
        if (reset || hazard.flush)
            fd <= '0;
        else if (!hazard.stall)  // hold while load-use pair waits
            fd <= fd_next;
    end

    // ****************************************
    // D - decode and register read
    // ****************************************

    ctrl_word_t  ctrl_d;
    logic [31:0] rf_data_a;
    logic [31:0] rf_data_b;
    logic [31:0] debug_data;
    logic [31:0] wb_data;

    cpu_control control_i (
        .instruction (fd.instruction),
        .ctrl        (ctrl_d)
    );

    cpu_register_file register_file_i (
        .clk          (clk),
        .read_addr_a  (fd.instruction[25:21]),
        .read_addr_b  (fd.instruction[20:16]),
        .debug_addr   (reg_addr),
        .write_addr   (mw.dest),
        .write_data   (wb_data),
        .write_enable (mw.reg_write),
        .read_data_a  (rf_data_a),
        .read_data_b  (rf_data_b),
        .debug_data   (debug_data)
    );

    assign reg_data = (reg_addr != '0) ? debug_data : pc;

    always_comb begin
        de_next.ctrl      = ctrl_d;
        de_next.operand_a = rf_data_a;
        de_next.operand_b = rf_data_b;
        de_next.imm       = {{16{fd.instruction[15]}}, fd.instruction[15:0]};
        de_next.rs        = fd.instruction[25:21];
        de_next.rt        = fd.instruction[20:16];
        de_next.rd        = fd.instruction[15:11];
        de_next.shamt     = fd.instruction[10:6];
        de_next.pc_next   = fd.pc_next;
    end

    always_ff @(posedge clk) begin
        if (reset || hazard.flush || hazard.stall)
            de <= '0;  // bubble
        else
            de <= de_next;
    end

    // ****************************************
    // E - execute
    // ****************************************

    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [4:0]  exec_dest;

    always_comb begin
        case (hazard.forward_a)
            FW_MEM:  fwd_a = em.alu_result;
            FW_WB:   fwd_a = wb_data;
            default: fwd_a = de.operand_a;
        endcase
        case (hazard.forward_b)
            FW_MEM:  fwd_b = em.alu_result;
            FW_WB:   fwd_b = wb_data;
            default: fwd_b = de.operand_b;
        endcase
    end

    assign alu_b     = de.ctrl.alu_src ? de.imm : fwd_b;
    assign exec_dest = de.ctrl.reg_dst ? de.rd : de.rt;

    cpu_alu alu_i (
        .src_a  (fwd_a),
        .src_b  (alu_b),
        .op     (de.ctrl.alu_op),
        .shamt  (de.shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_comb begin
        em_next.ctrl          = de.ctrl;
        em_next.alu_result    = alu_result;
        em_next.zero          = alu_zero;
        em_next.store_data    = fwd_b;  // rt, forwarded for sw
        em_next.dest          = exec_dest;
        em_next.branch_target = de.pc_next + de.imm;
    end

    always_ff @(posedge clk) begin
        if (reset || hazard.flush)
            em <= '0;
        else
            em <= em_next;
    end

    // ****************************************
    // M - memory and branch decision
    // ****************************************

    always_comb begin
        dmem.addr  = em.alu_result;
        dmem.wdata = em.store_data;
        dmem.we    = em.ctrl.mem_write;
    end

    // beq taken on zero, bne on nonzero
    assign branch_taken = em.ctrl.branch && (em.zero != em.ctrl.branch_ne);

    always_comb begin
        mw_next.reg_write  = em.ctrl.reg_write;
        mw_next.mem_to_reg = em.ctrl.mem_to_reg;
        mw_next.alu_result = em.alu_result;
        mw_next.load_data  = dmem_rdata;
        mw_next.dest       = em.dest;
    end

    always_ff @(posedge clk) begin
        if (reset)
            mw <= '0;
        else
            mw <= mw_next;
    end

    // ****************************************
    // W - writeback
    // ****************************************

    assign wb_data = mw.mem_to_reg ? mw.load_data : mw.alu_result;

    cpu_hazard_unit hazard_unit_i (
        .de_rs         (de.rs),
        .de_rt         (de.rt),
        .fd_rs         (fd.instruction[25:21]),
        .fd_rt         (fd.instruction[20:16]),
        .em            (em),
        .mw            (mw),
        .de_dest       (exec_dest),
        .de_mem_to_reg (de.ctrl.mem_to_reg),
        .branch_taken  (branch_taken),
        .hazard        (hazard)
    );

endmodule

/* cpu_ram.sv */
module cpu_ram #(
    parameter int DEPTH = 64
) (
    input  logic        clk,
    input  logic        write_enable,
    input  logic [31:0] write_addr,   // word address
    input  logic [31:0] write_data,
    input  logic [31:0] read_addr,
    output logic [31:0] read_data
);
    localparam int ADDR_BITS = $clog2(DEPTH);

    logic [31:0] mem [DEPTH];

    // upper address bits ignored, contents repeat
    always_ff @(posedge clk) begin
        if (write_enable)
            mem[write_addr[ADDR_BITS-1:0]] <= write_data;
    end

    assign read_data = mem[read_addr[ADDR_BITS-1:0]]; // same cycle read

endmodule

/* cpu_top.sv */
`include "cpu_settings.svh"

module cpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_we,    // program load into instruction memory
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic [4:0]  reg_addr,
    output logic [31:0] reg_data
);
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    dmem_req_t   dmem;
    logic [31:0] dmem_rdata;

    cpu_pipeline pipeline_i (
        .clk        (clk),
        .reset      (reset),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata)
    );

    // written only by the program loader
    cpu_ram #(.DEPTH(`CPU_IMEM_DEPTH)) imem_i (
        .clk          (clk),
        .write_enable (load_we),
        .write_addr   (load_addr),
        .write_data   (load_data),
        .read_addr    (imem_addr),
        .read_data    (imem_data)
    );

    cpu_ram #(.DEPTH(`CPU_DMEM_DEPTH)) dmem_i (
        .clk          (clk),
        .write_enable (dmem.we),
        .write_addr   (dmem.addr),
        .write_data   (dmem.wdata),
        .read_addr    (dmem.addr),
        .read_data    (dmem_rdata)
    );

endmodule

/* cpu_tb.sv */
`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS      = 6;
    localparam int ROW_WORDS = 16;
    localparam int DMEM_BITS = $clog2(`CPU_DMEM_DEPTH);

    logic        clk = 1'b0;
    logic        reset;
    logic        load_we;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data;

    logic [31:0] program_mem [ROWS][ROW_WORDS];  // test table, one program per row
    int          program_len [ROWS];

    // sequential reference state, kept across rows like the DUT
    logic [31:0] model_regs [`CPU_REG_COUNT];
    logic        reg_written [`CPU_REG_COUNT];
    logic [31:0] model_mem [`CPU_DMEM_DEPTH];

    int cycle_count = 0;
    int cycle_limit = 0;

    cpu_top cpu_top_i (
        .clk       (clk),
        .reset     (reset),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .reg_addr  (reg_addr),
        .reg_data  (reg_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // ****************************************
    // instruction encoding
    // ****************************************

    // field order rs, rt as in the machine word
    function automatic logic [31:0] itype(input opcode_t op, input int rs, input int rt,
                                          input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] rtype(input funct_t fn, input int rd, input int rs,
                                          input int rt);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] shift(input funct_t fn, input int rd, input int rt,
                                          input int sh);
        return {OP_SPECIAL, 5'd0, rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    task automatic emit(input int row, input logic [31:0] word);
        program_mem[row][program_len[row]] = word;
        program_len[row]++;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ****************************************
    // reference model
    // ****************************************

    function automatic void model_write(input logic [4:0] r, input logic [31:0] value);
        if (r != 5'd0) begin  // $0 stays zero
            model_regs[r]  = value;
            reg_written[r] = 1'b1;
        end
    endfunction

    // one instruction per step, no delay slots, stops at the self-branch
    task automatic run_model(input int row, output logic [31:0] halt_pc);
        logic [31:0]          pc;
        logic [31:0]          this_pc;
        logic [31:0]          w;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          imm;
        logic [4:0]           rd;
        logic [4:0]           rt;
        logic [DMEM_BITS-1:0] maddr;
        pc = '0;
        halt_pc = '1;
        for (int step = 0; step < 64; step++) begin
            this_pc = pc;
            w       = program_mem[row][pc[3:0]];
            a       = model_regs[w[25:21]];
            b       = model_regs[w[20:16]];
            rt      = w[20:16];
            rd      = w[15:11];
            imm     = {{16{w[15]}}, w[15:0]};
            maddr   = DMEM_BITS'(a + imm);  // data memory repeats above its depth
            pc      = pc + 32'd1;
            case (w[31:26])
                OP_SPECIAL: begin
                    case (w[5:0])
                        FN_ADDU: model_write(rd, a + b);
                        FN_SUBU: model_write(rd, a - b);
                        FN_AND:  model_write(rd, a & b);
                        FN_OR:   model_write(rd, a | b);
                        FN_SLT:  model_write(rd, {31'b0, $signed(a) < $signed(b)});
                        FN_SLL:  model_write(rd, b << w[10:6]);
                        FN_SRL:  model_write(rd, b >> w[10:6]);
                        default: ;
                    endcase
                end
                OP_ADDIU: model_write(rt, a + imm);
                OP_LUI:   model_write(rt, {w[15:0], 16'h0});
                OP_LW:    model_write(rt, model_mem[maddr]);
                OP_SW:    model_mem[maddr] = b;
                OP_BEQ, OP_BNE: begin
                    if ((a == b) != (w[31:26] == OP_BNE)) begin
                        if (pc + imm == this_pc) begin
                            halt_pc = this_pc;
                            return;
                        end
                        pc = pc + imm;
                    end
                end
                default: ;
            endcase
        end
        $display("reference model never reached the closing self-branch of row %0d", row);
        $display("TEST FAILED");
        $fatal(1, "model ran away");
    endtask

    // ****************************************
    // test table
    // ****************************************

    task automatic add_random_row(input int row);
        emit(row, itype(OP_LUI, 0, 28, int'($urandom % 65536)));
        emit(row, itype(OP_ADDIU, 28, 28, int'($urandom % 65536)));
        emit(row, shift(FN_SLL, 29, 28, int'($urandom % 32)));
        emit(row, shift(FN_SRL, 30, 29, int'($urandom % 32)));
        emit(row, itype(OP_ADDIU, 30, 31, int'($urandom % 65536)));
        emit(row, rtype(FN_ADDU, 29, 29, 31));
        emit(row, shift(FN_SRL, 28, 31, int'($urandom % 32)));
        emit(row, shift(FN_SLL, 30, 28, int'($urandom % 32)));
        emit(row, rtype(FN_SLT, 31, 30, 29));
    endtask

    task automatic build_table();
        // dependent alu chain, forwarding from M and W
        emit(0, itype(OP_ADDIU, 0, 1, 5));
        emit(0, itype(OP_ADDIU, 0, 2, -3));
        emit(0, rtype(FN_ADDU, 3, 1, 2));
        emit(0, rtype(FN_SUBU, 4, 3, 1));
        emit(0, rtype(FN_AND, 5, 4, 3));
        emit(0, rtype(FN_OR, 6, 5, 1));
        emit(0, rtype(FN_SLT, 7, 2, 1));
        emit(0, rtype(FN_SLT, 8, 1, 2));
        emit(0, rtype(FN_ADDU, 9, 7, 6));
        // store, load, then use at once
        emit(1, itype(OP_ADDIU, 0, 10, 'h1234));
        emit(1, itype(OP_ADDIU, 0, 11, 7));
        emit(1, itype(OP_SW, 11, 10, 0));
        emit(1, itype(OP_LW, 11, 12, 0));
        emit(1, rtype(FN_ADDU, 13, 12, 12));
        emit(1, itype(OP_SW, 11, 13, 1));
        emit(1, itype(OP_LW, 11, 14, 1));
        emit(1, rtype(FN_OR, 15, 14, 0));
        emit(1, itype(OP_LW, 11, 16, 0));
        emit(1, rtype(FN_SUBU, 17, 16, 13));
        // branches, skipped code targets registers known from row 0
        emit(2, itype(OP_ADDIU, 0, 18, 4));
        emit(2, itype(OP_ADDIU, 0, 19, 4));
        emit(2, itype(OP_BEQ, 18, 19, 2));   // taken
        emit(2, itype(OP_ADDIU, 0, 1, 99));
        emit(2, itype(OP_ADDIU, 0, 2, 99));
        emit(2, itype(OP_BNE, 18, 19, 1));   // not taken
        emit(2, itype(OP_ADDIU, 0, 22, 1));
        emit(2, itype(OP_BNE, 18, 0, 2));    // taken
        emit(2, itype(OP_ADDIU, 0, 3, 55));
        emit(2, itype(OP_ADDIU, 0, 4, 66));
        emit(2, itype(OP_BEQ, 18, 0, 1));    // not taken
        emit(2, itype(OP_ADDIU, 0, 25, 2));
        // writes to $0 and readers right after
        emit(3, itype(OP_ADDIU, 0, 0, 77));
        emit(3, rtype(FN_ADDU, 0, 1, 1));
        emit(3, rtype(FN_ADDU, 26, 0, 0));
        emit(3, itype(OP_LUI, 0, 0, 'hffff));
        emit(3, rtype(FN_OR, 27, 0, 1));
        add_random_row(4);
        add_random_row(5);
        for (int row = 0; row < ROWS; row++)
            emit(row, itype(OP_BEQ, 0, 0, -1));  // park on a self-branch
    endtask

    task automatic run_row(input int row);
        logic [31:0] halt_pc;
        logic [31:0] pc_seen;
        reset = 1'b1;
        for (int i = 0; i < ROW_WORDS; i++) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = 32'(i);
            load_data = program_mem[row][i];
        end
        @(negedge clk);
        load_we  = 1'b0;
        reg_addr = 5'd0;
        repeat (5) @(negedge clk);
        check_value("pc during reset", reg_data, 32'd0);
        reset = 1'b0;
        repeat (4 * program_len[row] + 12) @(negedge clk);
        run_model(row, halt_pc);
        for (int i = 1; i < 32; i++) begin
            reg_addr = 5'(i);
            @(negedge clk);
            if (reg_written[i])
                check_value($sformatf("r%0d", i), reg_data, model_regs[i]);
        end
        reg_addr = 5'd0;
        pc_seen  = '1;
        // self-branch loop walks pc through b..b+3
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (pc_seen !== halt_pc)
                pc_seen = reg_data;
        end
        check_value("pc", pc_seen, halt_pc);
    endtask

    initial begin
        reset     = 1'b1;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        reg_addr  = '0;
        void'($urandom(55));
        for (int row = 0; row < ROWS; row++) begin
            program_len[row] = 0;
            for (int i = 0; i < ROW_WORDS; i++)
                program_mem[row][i] = '0;
        end
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            model_regs[i]  = '0;
            reg_written[i] = 1'b0;
        end
        build_table();
        cycle_limit = 100;
        for (int row = 0; row < ROWS; row++)
            cycle_limit += 70 + 4 * program_len[row];  // load, reset, run, readout
        for (int row = 0; row < ROWS; row++)
            run_row(row);
        $display("TEST OK");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
cpu_pkg.sv
cpu_control.sv
cpu_alu.sv
cpu_register_file.sv
cpu_hazard_unit.sv
cpu_pipeline.sv
cpu_ram.sv
cpu_top.sv
cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module cpu_tb \
    --Mdir obj_dir -o cpu_sim

# a fatal stop exits nonzero, keep the output for the search
output=$(./obj_dir/cpu_sim 2>&1) || true
echo "$output"
if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
